/* project.f */
verilog/md_op_pkg.sv
verilog/md_ctrl_pkg.sv
verilog/mult_mac.sv
verilog/div_long.sv
verilog/multdiv_top.sv
verif/multdiv_assert.sv
verif/multdiv_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the multiply/divide unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module multdiv_tb \
  -f project.f \
  -o multdiv_sim

./obj_dir/multdiv_sim

/* verif/multdiv_assert.sv */
/*
 * Handshake checks for the multiply/divide unit, bound into the top level
 */
`timescale 1ns/1ps
`default_nettype none

module multdiv_assert
  import md_op_pkg::*;
(
  input logic    clk_i,
  input logic    rst_ni,
  input logic    en_i,
  input logic    ready_i,
  input logic    valid_i,
  input md_rsp_t rsp_i
);

  // Nothing pending straight out of reset
  valid_low_after_reset: assert property (@(posedge clk_i) $rose(rst_ni) |-> !valid_i)
    else $error("valid_o high in the first cycle after reset");

  valid_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i && !ready_i |=> valid_i)
    else $error("valid_o dropped before the result was accepted");

  rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i && !ready_i |=> $stable(rsp_i))
    else $error("rsp_o changed while waiting for ready_i");

  // An engine only answers a request that is still enabled
  no_valid_without_en: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !en_i |-> !valid_i)
    else $error("valid_o high while en_i is low");

endmodule

bind multdiv_top multdiv_assert u_assert (
  .clk_i   (clk_i),
  .rst_ni  (rst_ni),
  .en_i    (en_i),
  .ready_i (ready_i),
  .valid_i (valid_o),
  .rsp_i   (rsp_o)
);

`default_nettype wire

/* verif/multdiv_tb.sv */
/*
 * Testbench for the multiply/divide unit
 * Directed tests checked against a reference model of the RISC-V M extension
 */
`timescale 1ns/1ps
`default_nettype none

module multdiv_tb
  import md_op_pkg::*;
();

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  localparam int MAX_WAIT     = 40;
  // Operations issued over all tests, and the cycle budget for each
  localparam int NUM_OPS      = 72;
  localparam int OP_BUDGET    = 45;
  localparam int WATCHDOG_NS  = (NUM_OPS * OP_BUDGET + RESET_CYCLES) * CLK_PERIOD;

  // Latency in cycles counted from the first cycle with en_i high
  localparam int MUL_LAT      = 3;
  localparam int MULH_LAT     = 4;
  localparam int DIV_LAT      = 37;
  localparam int DIV_ZERO_LAT = 2;

  localparam logic [XLEN-1:0] MIN_INT = 32'h8000_0000;

  logic            clk_i;
  logic            rst_ni;
  logic            en_i;
  logic            ready_i;
  logic            valid_o;
  md_req_t         req_i;
  md_rsp_t         rsp_o;
  logic [XLEN-1:0] lfsr_state;

  multdiv_top UUT (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .en_i    (en_i),
    .req_i   (req_i),
    .ready_i (ready_i),
    .valid_o (valid_o),
    .rsp_o   (rsp_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at the first error");
  endtask

  initial begin
    #(WATCHDOG_NS);
    stop_run("Watchdog expired: the tests did not finish in the expected time");
  end

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [XLEN-1:0] lfsr_next(input logic [XLEN-1:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic rand_bits(input int n, output logic [XLEN-1:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[XLEN-2:0], lfsr_state[0]};
    end
  endtask

  function automatic string op_name(input md_op_e op);
    case (op)
      MD_OP_MUL:  return "MUL";
      MD_OP_MULH: return "MULH";
      MD_OP_DIV:  return "DIV";
      default:    return "REM";
    endcase
  endfunction

  function automatic md_req_t make_req(input md_op_e op, input logic sa, input logic sb,
                                       input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    md_req_t r;
    r.op     = op;
    r.sign_a = sa;
    r.sign_b = sb;
    r.op_a   = a;
    r.op_b   = b;
    return r;
  endfunction

  // M extension results with per-operand signedness
  function automatic logic [XLEN-1:0] ref_result(input md_req_t r);
    logic [2*XLEN-1:0] ext_a;
    logic [2*XLEN-1:0] ext_b;
    logic [2*XLEN-1:0] prod;
    logic              neg_a;
    logic              neg_b;
    logic [XLEN-1:0]   mag_a;
    logic [XLEN-1:0]   mag_b;
    logic [XLEN-1:0]   quot;
    logic [XLEN-1:0]   rem_v;
    neg_a = r.sign_a & r.op_a[XLEN-1];
    neg_b = r.sign_b & r.op_b[XLEN-1];
    ext_a = {{XLEN{neg_a}}, r.op_a};
    ext_b = {{XLEN{neg_b}}, r.op_b};
    prod  = ext_a * ext_b;
    mag_a = neg_a ? -r.op_a : r.op_a;
    mag_b = neg_b ? -r.op_b : r.op_b;
    quot  = '1;
    rem_v = r.op_a;
    // Truncating division on magnitudes with the remainder taking the dividend sign
    if (r.op_b != '0) begin
      quot  = mag_a / mag_b;
      rem_v = mag_a % mag_b;
      if (neg_a ^ neg_b) quot = -quot;
      if (neg_a) rem_v = -rem_v;
    end
    case (r.op)
      MD_OP_MUL:  return prod[XLEN-1:0];
      MD_OP_MULH: return prod[2*XLEN-1:XLEN];
      MD_OP_DIV:  return quot;
      default:    return rem_v;
    endcase
  endfunction

  function automatic int expected_latency(input md_req_t r);
    case (r.op)
      MD_OP_MUL:  return MUL_LAT;
      MD_OP_MULH: return MULH_LAT;
      default:    return (r.op_b == '0) ? DIV_ZERO_LAT : DIV_LAT;
    endcase
  endfunction

  task automatic check_value(input string what, input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp_val);
    assert (got === exp_val) else
      stop_run($sformatf("FAIL at %0t: %s result %08h, expected %08h",
                         $time, what, got, exp_val));
  endtask

  // Issue one request, hold ready_i low for hold_cycles once valid, then accept
  task automatic run_op(input md_req_t r, input int hold_cycles);
    logic [XLEN-1:0] exp_val;
    int              exp_lat;
    int              cyc;
    string           what;
    exp_val = ref_result(r);
    exp_lat = expected_latency(r);
    what = $sformatf("%s sa=%0b sb=%0b a=%08h b=%08h",
                     op_name(r.op), r.sign_a, r.sign_b, r.op_a, r.op_b);
    @(negedge clk_i);
    req_i   = r;
    en_i    = 1'b1;
    ready_i = (hold_cycles == 0);
    #1;
    cyc = 1;
    while (!valid_o && cyc < MAX_WAIT) begin
      @(negedge clk_i);
      cyc++;
    end
    assert (valid_o) else
      stop_run($sformatf("Timeout: valid_o did not rise within %0d cycles for %s",
                         MAX_WAIT, what));
    assert (cyc == exp_lat) else
      stop_run($sformatf("FAIL at %0t: %s valid in cycle %0d, expected cycle %0d",
                         $time, what, cyc, exp_lat));
    check_value(what, rsp_o.result, exp_val);
    for (int k = 0; k < hold_cycles; k++) begin
      @(negedge clk_i);
      assert (valid_o) else
        stop_run($sformatf("valid_o dropped while ready_i was low for %s", what));
      check_value(what, rsp_o.result, exp_val);
    end
    ready_i = 1'b1;
    // Transfer edge
    @(posedge clk_i);
  endtask

  task automatic release_bus();
    @(negedge clk_i);
    en_i    = 1'b0;
    ready_i = 1'b0;
  endtask

  task automatic run_pair(input md_op_e op_x, input md_op_e op_y, input logic sa,
                          input logic sb, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b);
    run_op(make_req(op_x, sa, sb, a, b), 0);
    release_bus();
    run_op(make_req(op_y, sa, sb, a, b), 0);
    release_bus();
  endtask

  task automatic mul_sweep();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    for (int s = 0; s < 4; s++) begin
      for (int i = 0; i < 4; i++) begin
        rand_bits(XLEN, a);
        rand_bits(XLEN, b);
        run_pair(MD_OP_MUL, MD_OP_MULH, s[1], s[0], a, b);
      end
    end
  endtask

  task automatic div_sweep();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] sg;
    logic [XLEN-1:0] neg;
    logic [XLEN-1:0] sh;
    for (int i = 0; i < 8; i++) begin
      rand_bits(1, sg);
      rand_bits(1, neg);
      rand_bits(5, sh);
      rand_bits(XLEN, a);
      rand_bits(XLEN, b);
      // Smaller divisors give quotients wider than one bit
      b = b >> sh[4:0];
      if (sg[0] && neg[0]) b = -b;
      if (b == '0) b = 32'd1;
      run_pair(MD_OP_DIV, MD_OP_REM, sg[0], sg[0], a, b);
    end
    run_pair(MD_OP_DIV, MD_OP_REM, 1'b1, 1'b1, -32'd7, 32'd2);
    run_pair(MD_OP_DIV, MD_OP_REM, 1'b1, 1'b1, 32'd7, -32'd2);
    run_pair(MD_OP_DIV, MD_OP_REM, 1'b1, 1'b1, -32'd7, -32'd2);
  endtask

  task automatic zero_divisor();
    logic [XLEN-1:0] a;
    for (int s = 0; s < 2; s++) begin
      rand_bits(XLEN, a);
      run_pair(MD_OP_DIV, MD_OP_REM, s[0], s[0], a, 32'd0);
    end
  endtask

  task automatic corner_cases();
    logic [XLEN-1:0] x;
    rand_bits(XLEN, x);
    x = x | 32'd1;
    run_pair(MD_OP_DIV, MD_OP_REM, 1'b1, 1'b1, MIN_INT, 32'hFFFF_FFFF);
    run_pair(MD_OP_DIV, MD_OP_REM, 1'b1, 1'b1, 32'd0, x);
    run_pair(MD_OP_MUL, MD_OP_MULH, 1'b1, 1'b0, x, 32'd0);
    run_op(make_req(MD_OP_MULH, 1'b1, 1'b1, MIN_INT, MIN_INT), 0);
    release_bus();
    run_op(make_req(MD_OP_MULH, 1'b0, 1'b0, 32'hFFFF_FFFF, 32'hFFFF_FFFF), 0);
    release_bus();
  endtask

  task automatic backpressure();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] hv;
    for (int i = 0; i < 4; i++) begin
      rand_bits(3, hv);
      rand_bits(XLEN, a);
      rand_bits(XLEN, b);
      if (b == '0) b = 32'd3;
      run_op(make_req(md_op_e'(i[1:0]), 1'b1, 1'b1, a, b), 2 + int'(hv[2:0]));
      release_bus();
    end
  endtask

  // MULH issued in the cycle right after the DIV result is taken
  task automatic back_to_back();
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    rand_bits(XLEN, a);
    rand_bits(XLEN, b);
    b = b | 32'd1;
    run_op(make_req(MD_OP_DIV, 1'b1, 1'b1, a, b), 0);
    rand_bits(XLEN, a);
    rand_bits(XLEN, b);
    run_op(make_req(MD_OP_MULH, 1'b1, 1'b1, a, b), 0);
    release_bus();
  endtask

  initial begin
    rst_ni     = 1'b0;
    en_i       = 1'b0;
    ready_i    = 1'b0;
    req_i      = '0;
    lfsr_state = 32'd4;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    mul_sweep();
    div_sweep();
    zero_divisor();
    corner_cases();
    backpressure();
    back_to_back();
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/div_long.sv */
/*
 * Restoring long divider
 * Takes absolute values, produces one quotient bit per cycle and fixes the
 * sign at the end, with a shortcut for a zero divisor
 */
`timescale 1ns/1ps
`default_nettype none

module div_long
  import md_op_pkg::*;
  import md_ctrl_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            en_i,
  input  logic            ready_i,
  input  md_req_t         req_i,
  output logic            valid_o,
  output logic [XLEN-1:0] result_o
);

  div_state_e        state_q;
  div_state_e        state_d;
  logic [CNT_W-1:0]  cnt_q;
  logic [CNT_W-1:0]  cnt_d;
  logic [XLEN-1:0]   num_q;
  logic [XLEN-1:0]   num_d;
  logic [XLEN-1:0]   den_q;
  logic [XLEN-1:0]   den_d;
  logic [XLEN-1:0]   quot_q;
  logic [XLEN-1:0]   quot_d;
  logic [XLEN:0]     rem_q;
  logic [XLEN:0]     rem_d;

  // Shared subtractor with the borrow in the top bit
  logic [XLEN:0]     sub_a;
  logic [XLEN:0]     sub_b;
  logic [XLEN+1:0]   sub_res;
  logic              is_greater_equal;
  logic              div_zero;

  logic [XLEN-1:0]   one_shift;
  logic [XLEN-1:0]   next_rem;
  logic [XLEN-1:0]   next_quot;
  logic              sign_a;
  logic              sign_b;
  logic              quot_change_sign;
  logic              rem_change_sign;
  logic              is_div;
  logic              hold;
  logic              step_en;

  assign sub_res = {1'b0, sub_a} - {1'b0, sub_b};
  // 0 - b is zero only for b == 0
  assign div_zero = (sub_res[XLEN:0] == '0);
  assign is_greater_equal = ~sub_res[XLEN+1];

  assign sign_a = req_i.sign_a & req_i.op_a[XLEN-1];
  assign sign_b = req_i.sign_b & req_i.op_b[XLEN-1];
  assign is_div = (req_i.op == MD_OP_DIV);

  assign quot_change_sign = (sign_a ^ sign_b) & (den_q != '0);
  assign rem_change_sign  = sign_a;

  // Remainder stays below the divisor, so 32 bits hold the difference
  assign one_shift = {{(XLEN-1){1'b0}}, 1'b1} << cnt_q;
  assign next_rem  = is_greater_equal ? sub_res[XLEN-1:0] : rem_q[XLEN-1:0];
  assign next_quot = is_greater_equal ? (quot_q | one_shift) : quot_q;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    num_d   = num_q;
    den_d   = den_q;
    quot_d  = quot_q;
    rem_d   = rem_q;
    sub_a   = '0;
    sub_b   = {1'b0, req_i.op_b};
    valid_o = 1'b0;
    hold    = 1'b0;

    unique case (state_q)
      DIV_IDLE: begin
        // Division by zero result that stays when the divisor is zero
        rem_d   = is_div ? '1 : {1'b0, req_i.op_a};
        state_d = div_zero ? DIV_FINISH : DIV_ABS_A;
      end

      DIV_ABS_A: begin
        sub_b   = {1'b0, req_i.op_a};
        num_d   = sign_a ? sub_res[XLEN-1:0] : req_i.op_a;
        quot_d  = '0;
        state_d = DIV_ABS_B;
      end

      DIV_ABS_B: begin
        den_d   = sign_b ? sub_res[XLEN-1:0] : req_i.op_b;
        // First dividend bit enters the remainder
        rem_d   = {{XLEN{1'b0}}, num_q[XLEN-1]};
        cnt_d   = CNT_W'(DIV_STEPS);
        state_d = DIV_COMP;
      end

      DIV_COMP: begin
        sub_a   = rem_q;
        sub_b   = {1'b0, den_q};
        cnt_d   = cnt_q - 1'b1;
        quot_d  = next_quot;
        rem_d   = {next_rem, num_q[cnt_d]};
        state_d = (cnt_q == CNT_W'(1)) ? DIV_LAST : DIV_COMP;
      end

      DIV_LAST: begin
        // Quotient bit 0 and only the part the operation returns
        sub_a   = rem_q;
        sub_b   = {1'b0, den_q};
        rem_d   = is_div ? {1'b0, next_quot} : {1'b0, next_rem};
        state_d = DIV_SIGN;
      end

      DIV_SIGN: begin
        sub_b = {1'b0, rem_q[XLEN-1:0]};
        if (is_div ? quot_change_sign : rem_change_sign) begin
          rem_d = {1'b0, sub_res[XLEN-1:0]};
        end
        state_d = DIV_FINISH;
      end

      DIV_FINISH: begin
        valid_o = 1'b1;
        hold    = ~ready_i;
        state_d = DIV_IDLE;
      end

      default: begin
        state_d = DIV_IDLE;
      end
    endcase
  end

  assign step_en  = en_i & ~hold;
  assign result_o = rem_q[XLEN-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
    end else if (step_en) begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (step_en) begin
      num_q  <= num_d;
      den_q  <= den_d;
      quot_q <= quot_d;
      rem_q  <= rem_d;
    end
  end

endmodule

`default_nettype wire

/* verilog/md_ctrl_pkg.sv */
/*
 * Multiply/divide engine internals
 * FSM encodings, MAC slice widths and divider counter constants
 */
`default_nettype none

package md_ctrl_pkg;

  // One operand slice fed to the 17x17 MAC
  localparam int HALF_W = 16;
  // Accumulator holds a 32 bit partial sum plus two guard bits
  localparam int ACC_W = 34;

  // Iteration count loaded before the compare phase
  localparam int DIV_STEPS = 31;
  localparam int CNT_W = 5;

  // Named after the operand halves multiplied in each step
  typedef enum logic [1:0] {
    ALBL, ALBH, AHBL, AHBH
  } mult_state_e;

  typedef enum logic [2:0] {
    DIV_IDLE, DIV_ABS_A, DIV_ABS_B, DIV_COMP, DIV_LAST, DIV_SIGN, DIV_FINISH
  } div_state_e;

endpackage

`default_nettype wire

/* verilog/md_op_pkg.sv */
/*
 * Multiply/divide unit boundary definitions
 * Operation codes plus the request and response words seen by the requester
 */
`default_nettype none

package md_op_pkg;

  // Data word width
  localparam int XLEN = 32;

  typedef enum logic [1:0] {
    MD_OP_MUL  = 2'b00,
    MD_OP_MULH = 2'b01,
    MD_OP_DIV  = 2'b10,
    MD_OP_REM  = 2'b11
  } md_op_e;

  // Sign bits mark an operand as two's complement
  typedef struct packed {
    md_op_e            op;
    logic              sign_a;
    logic              sign_b;
    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   op_b;
  } md_req_t;

  typedef struct packed {
    logic [XLEN-1:0] result;
  } md_rsp_t;

endpackage

`default_nettype wire

/* verilog/mult_mac.sv */
/*
 * Multi-cycle multiplier
 * One 17x17 signed multiply-accumulate stepped over the four 16 bit partial
 * products, 3 cycles for MUL and 4 cycles for MULH
 */
`timescale 1ns/1ps
`default_nettype none

module mult_mac
  import md_op_pkg::*;
  import md_ctrl_pkg::*;
(
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            en_i,
  input  logic            ready_i,
  input  md_req_t         req_i,
  output logic            valid_o,
  output logic [XLEN-1:0] result_o
);

  mult_state_e             state_q;
  mult_state_e             state_d;
  logic [ACC_W-1:0]        acc_q;
  logic [ACC_W-1:0]        acc_d;
  logic [ACC_W-1:0]        accum;
  logic signed [ACC_W-1:0] mac_res;
  logic [HALF_W-1:0]       mac_op_a;
  logic [HALF_W-1:0]       mac_op_b;
  logic                    mac_sign_a;
  logic                    mac_sign_b;
  logic                    op_sign_a;
  logic                    op_sign_b;
  logic                    signed_mult;
  logic                    is_mulh;
  logic                    hold;
  logic                    step_en;

  // Operand is negative only when it is treated as signed
  assign op_sign_a   = req_i.sign_a & req_i.op_a[XLEN-1];
  assign op_sign_b   = req_i.sign_b & req_i.op_b[XLEN-1];
  assign signed_mult = req_i.sign_a | req_i.sign_b;
  assign is_mulh     = (req_i.op == MD_OP_MULH);

  // Top two bits of the 35 bit sum always agree, so 34 bits are enough
  assign mac_res = $signed({mac_sign_a, mac_op_a}) * $signed({mac_sign_b, mac_op_b})
                 + $signed(accum);

  always_comb begin
    mac_op_a   = req_i.op_a[HALF_W-1:0];
    mac_op_b   = req_i.op_b[HALF_W-1:0];
    mac_sign_a = 1'b0;
    mac_sign_b = 1'b0;
    accum      = acc_q;
    acc_d      = mac_res;
    state_d    = state_q;
    valid_o    = 1'b0;
    hold       = 1'b0;

    unique case (state_q)
      ALBL: begin
        // al*bl starts from an empty accumulator
        accum   = '0;
        state_d = ALBH;
      end

      ALBH: begin
        // al*bh plus the upper half of the unsigned al*bl
        mac_op_b   = req_i.op_b[XLEN-1:HALF_W];
        mac_sign_b = op_sign_b;
        accum      = {{(ACC_W-HALF_W){1'b0}}, acc_q[XLEN-1:HALF_W]};
        if (!is_mulh) begin
          // Keep the final low half of the product under the running sum
          acc_d = {{(ACC_W-XLEN){1'b0}}, mac_res[HALF_W-1:0], acc_q[HALF_W-1:0]};
        end
        state_d = AHBL;
      end

      AHBL: begin
        // ah*bl
        mac_op_a   = req_i.op_a[XLEN-1:HALF_W];
        mac_sign_a = op_sign_a;
        if (!is_mulh) begin
          accum   = {{(ACC_W-HALF_W){1'b0}}, acc_q[XLEN-1:HALF_W]};
          acc_d   = {{(ACC_W-XLEN){1'b0}}, mac_res[HALF_W-1:0], acc_q[HALF_W-1:0]};
          valid_o = 1'b1;
          hold    = ~ready_i;
          state_d = ALBL;
        end else begin
          state_d = AHBH;
        end
      end

      AHBH: begin
        // ah*bh on top of the previous sum shifted down one slice
        mac_op_a   = req_i.op_a[XLEN-1:HALF_W];
        mac_op_b   = req_i.op_b[XLEN-1:HALF_W];
        mac_sign_a = op_sign_a;
        mac_sign_b = op_sign_b;
        accum      = {{HALF_W{signed_mult & acc_q[ACC_W-1]}}, acc_q[ACC_W-1:HALF_W]};
        valid_o    = 1'b1;
        hold       = ~ready_i;
        state_d    = ALBL;
      end

      default: begin
        state_d = ALBL;
      end
    endcase
  end

  // Freeze while the result waits for the consumer
  assign step_en  = en_i & ~hold;
  assign result_o = acc_d[XLEN-1:0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ALBL;
    end else if (step_en) begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (step_en) begin
      acc_q <= acc_d;
    end
  end

endmodule

`default_nettype wire

/* verilog/multdiv_top.sv */
/*
 * Multiply/divide unit top level
 * Routes the request enable to the multiplier or the divider and merges
 * their valid and result toward the consumer
 */
`timescale 1ns/1ps
`default_nettype none

module multdiv_top
  import md_op_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  logic    en_i,
  input  md_req_t req_i,
  input  logic    ready_i,
  output logic    valid_o,
  output md_rsp_t rsp_o
);

  logic            is_mult;
  logic            mult_en;
  logic            div_en;
  logic            mult_valid;
  logic            div_valid;
  logic [XLEN-1:0] mult_result;
  logic [XLEN-1:0] div_result;

  // MUL and MULH go to the MAC, DIV and REM to the divider
  assign is_mult = (req_i.op == MD_OP_MUL) | (req_i.op == MD_OP_MULH);
  assign mult_en = en_i & is_mult;
  assign div_en  = en_i & ~is_mult;

  mult_mac u_mult (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .en_i     (mult_en),
    .ready_i  (ready_i),
    .req_i    (req_i),
    .valid_o  (mult_valid),
    .result_o (mult_result)
  );

  div_long u_div (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .en_i     (div_en),
    .ready_i  (ready_i),
    .req_i    (req_i),
    .valid_o  (div_valid),
    .result_o (div_result)
  );

  // Only the engine that owns the current operation can be valid
  assign valid_o      = mult_valid | div_valid;
  assign rsp_o.result = is_mult ? mult_result : div_result;

endmodule

`default_nettype wire
